// ==== build.f ====
src/bp_pkg.sv
src/bp_index_stage.sv
src/pht_table.sv
src/bp_resolve_stage.sv
src/mispredict_stats.sv
src/bp_unit.sv
sim/bp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the branch predictor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module bp_tb \
    -f build.f \
    -o bp_sim

# the simulator exits with a failing status on $fatal
./obj_dir/bp_sim

// ==== sim/bp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_tb;
    import bp_pkg::*;

    logic                   clk;
    logic                   rst;
    logic                   pred_req;
    logic [PC_W-1:0]        pred_pc;
    logic                   pred_ack;
    logic                   pred_taken;
    logic [PHT_INDEX_W-1:0] pred_index;
    logic                   res_req;
    br_kind_t               res_kind;
    logic [PHT_INDEX_W-1:0] res_index;
    logic                   res_taken;
    logic                   res_mispred;
    logic                   res_ack;
    logic [STAT_W-1:0]      br_total;
    logic [STAT_W-1:0]      br_missed;
    logic [STAT_W-1:0]      jal_total;
    logic [STAT_W-1:0]      jal_missed;
    logic [STAT_W-1:0]      jalr_total;
    logic [STAT_W-1:0]      jalr_missed;

    // reference model of the gshare table and the statistics
    logic [1:0]             model_ctr [PHT_SIZE];
    logic [PHT_INDEX_W-1:0] model_ghr;
    logic [STAT_W-1:0]      model_total [3];
    logic [STAT_W-1:0]      model_missed [3];

    bp_unit bp_unit_i (
        .clk         (clk),
        .rst         (rst),
        .pred_req    (pred_req),
        .pred_pc     (pred_pc),
        .pred_ack    (pred_ack),
        .pred_taken  (pred_taken),
        .pred_index  (pred_index),
        .res_req     (res_req),
        .res_kind    (res_kind),
        .res_index   (res_index),
        .res_taken   (res_taken),
        .res_mispred (res_mispred),
        .res_ack     (res_ack),
        .br_total    (br_total),
        .br_missed   (br_missed),
        .jal_total   (jal_total),
        .jal_missed  (jal_missed),
        .jalr_total  (jalr_total),
        .jalr_missed (jalr_missed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // counts sampled edges until pred_ack reaches the level
    task automatic wait_pred_ack(input logic level, output int cycles);
        cycles = 0;
        while (pred_ack !== level && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pred_ack !== level) begin
            $display("timeout: pred_ack did not go to %0b within 50 cycles", level);
            $display("Simulation failed");
            $fatal(1, "prediction handshake hung");
        end
    endtask

    task automatic wait_res_ack(input logic level);
        int cycles;
        cycles = 0;
        while (res_ack !== level && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (res_ack !== level) begin
            $display("timeout: res_ack did not go to %0b within 50 cycles", level);
            $display("Simulation failed");
            $fatal(1, "resolve handshake hung");
        end
    endtask

    function automatic int kind_slot(input br_kind_t kind);
        case (kind)
            kind_jal:  return 1;
            kind_jalr: return 2;
            default:   return 0;
        endcase
    endfunction

    // pc that hashes to idx under the current model history
    function automatic logic [PC_W-1:0] pc_for_index(input logic [PHT_INDEX_W-1:0] idx,
                                                     input logic [22:0] upper);
        return {upper, idx ^ model_ghr, 2'b00};
    endfunction

    task automatic check_stats();
        check_value(br_total, model_total[0], "br_total");
        check_value(br_missed, model_missed[0], "br_missed");
        check_value(jal_total, model_total[1], "jal_total");
        check_value(jal_missed, model_missed[1], "jal_missed");
        check_value(jalr_total, model_total[2], "jalr_total");
        check_value(jalr_missed, model_missed[2], "jalr_missed");
    endtask

    task automatic predict_once(input logic [PC_W-1:0] pc, output logic taken,
                                output logic [PHT_INDEX_W-1:0] index, output int latency);
        logic [PHT_INDEX_W-1:0] exp_index;
        int                     drop_cycles;
        exp_index = pc[8:2] ^ model_ghr;
        pred_req  = 1'b1;
        pred_pc   = pc;
        wait_pred_ack(1'b1, latency);
        check_value(pred_index, exp_index, "prediction index");
        check_value(pred_taken, model_ctr[exp_index] >= 2'd2, "prediction direction");
        taken    = pred_taken;
        index    = pred_index;
        pred_req = 1'b0;
        wait_pred_ack(1'b0, drop_cycles);
    endtask

    task automatic resolve_once(input br_kind_t kind, input logic [PHT_INDEX_W-1:0] index,
                                input logic taken, input logic mispred);
        int slot;
        slot        = kind_slot(kind);
        res_req     = 1'b1;
        res_kind    = kind;
        res_index   = index;
        res_taken   = taken;
        res_mispred = mispred;
        wait_res_ack(1'b1);
        model_total[slot] = model_total[slot] + 32'd1;
        if (mispred) begin
            model_missed[slot] = model_missed[slot] + 32'd1;
        end
        // only conditional branches train and shift history
        if (kind == kind_br) begin
            if (taken && model_ctr[index] != 2'd3) begin
                model_ctr[index] = model_ctr[index] + 2'd1;
            end else if (!taken && model_ctr[index] != 2'd0) begin
                model_ctr[index] = model_ctr[index] - 2'd1;
            end
            model_ghr = {model_ghr[PHT_INDEX_W-2:0], taken};
        end
        res_req = 1'b0;
        wait_res_ack(1'b0);
        check_stats();
    endtask

    task automatic test_after_reset();
        logic [PC_W-1:0]        pc;
        logic                   taken;
        logic [PHT_INDEX_W-1:0] index;
        int                     latency;
        for (int i = 0; i < 6; i++) begin
            pc = $urandom;
            predict_once(pc, taken, index, latency);
            check_value(taken, 1'b0, "fresh table predicts not taken");
            check_value(index, pc[8:2], "index with zero history");
        end
    endtask

    task automatic test_train_saturate();
        logic [PHT_INDEX_W-1:0] idx;
        logic                   taken;
        logic [PHT_INDEX_W-1:0] index;
        int                     latency;
        idx = 7'h2a;
        resolve_once(kind_br, idx, 1'b1, 1'b1);
        resolve_once(kind_br, idx, 1'b1, 1'b0);
        predict_once(pc_for_index(idx, 23'h1f0), taken, index, latency);
        check_value(taken, 1'b1, "entry trained to taken");
        // third taken holds at 3 and one not taken only brings it to 2
        resolve_once(kind_br, idx, 1'b1, 1'b0);
        resolve_once(kind_br, idx, 1'b0, 1'b1);
        predict_once(pc_for_index(idx, 23'h3c), taken, index, latency);
        check_value(taken, 1'b1, "saturated entry still taken");
        repeat (2) resolve_once(kind_br, idx, 1'b0, 1'b1);
        predict_once(pc_for_index(idx, 23'h0), taken, index, latency);
        check_value(taken, 1'b0, "entry back to not taken");
        // not taken holds at 0 so one taken only reaches 1
        resolve_once(kind_br, idx, 1'b0, 1'b0);
        resolve_once(kind_br, idx, 1'b1, 1'b0);
        predict_once(pc_for_index(idx, 23'h55), taken, index, latency);
        check_value(taken, 1'b0, "entry at 1 after bottom saturation");
    endtask

    task automatic test_ghr_shift();
        logic [PC_W-1:0]        pc;
        logic                   taken;
        logic [PHT_INDEX_W-1:0] index;
        int                     latency;
        pc = 32'h0000_1234;
        // seven not-taken branches flush the history to zero
        repeat (7) resolve_once(kind_br, 7'h11, 1'b0, 1'b0);
        predict_once(pc, taken, index, latency);
        check_value(index, pc[8:2], "index after history flush");
        resolve_once(kind_br, 7'h33, 1'b1, 1'b0);
        predict_once(pc, taken, index, latency);
        check_value(index, pc[8:2] ^ 7'd1, "index after one taken branch");
    endtask

    task automatic test_jumps();
        logic [PC_W-1:0]        pcs [3];
        logic                   taken_before [3];
        logic [PHT_INDEX_W-1:0] index_before [3];
        logic                   taken;
        logic [PHT_INDEX_W-1:0] index;
        logic [STAT_W-1:0]      br_total_before;
        logic [STAT_W-1:0]      br_missed_before;
        int                     latency;
        br_total_before  = model_total[0];
        br_missed_before = model_missed[0];
        for (int i = 0; i < 3; i++) begin
            pcs[i] = $urandom;
            predict_once(pcs[i], taken_before[i], index_before[i], latency);
        end
        resolve_once(kind_jal, index_before[0], 1'b1, 1'b0);
        resolve_once(kind_jal, index_before[1], 1'b1, 1'b1);
        resolve_once(kind_jalr, index_before[2], 1'b1, 1'b1);
        resolve_once(kind_jalr, index_before[0], 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            predict_once(pcs[i], taken, index, latency);
            check_value(index, index_before[i], "index unchanged by jumps");
            check_value(taken, taken_before[i], "prediction unchanged by jumps");
        end
        check_value(br_total, br_total_before, "br_total unchanged by jumps");
        check_value(br_missed, br_missed_before, "br_missed unchanged by jumps");
    endtask

    task automatic test_random_run();
        logic [PC_W-1:0]        pc;
        logic [31:0]            r;
        logic                   taken;
        logic [PHT_INDEX_W-1:0] index;
        br_kind_t               kind;
        int                     latency;
        for (int i = 0; i < 40; i++) begin
            pc = $urandom;
            r  = $urandom;
            predict_once(pc, taken, index, latency);
            // first sampled edge is the accepting one
            check_value(latency - 1, 32'd2, "cycles from accept to pred_ack");
            case (r[7:4] % 3)
                1:       kind = kind_jal;
                2:       kind = kind_jalr;
                default: kind = kind_br;
            endcase
            resolve_once(kind, index, r[0], r[1]);
        end
    endtask

    initial begin
        rst         = 1'b1;
        pred_req    = 1'b0;
        pred_pc     = '0;
        res_req     = 1'b0;
        res_kind    = kind_br;
        res_index   = '0;
        res_taken   = 1'b0;
        res_mispred = 1'b0;
        model_ghr   = '0;
        for (int i = 0; i < PHT_SIZE; i++) begin
            model_ctr[i] = CTR_INIT;
        end
        for (int i = 0; i < 3; i++) begin
            model_total[i]  = '0;
            model_missed[i] = '0;
        end
        void'($urandom(9));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_after_reset();
        test_train_saturate();
        test_ghr_shift();
        test_jumps();
        test_random_run();

        $display("Simulation passed");
        $finish;
    end

endmodule : bp_tb

`default_nettype wire

// ==== src/bp_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_unit (
    input  logic                           clk,
    input  logic                           rst,

    // prediction port
    input  logic                           pred_req,
    input  logic [bp_pkg::PC_W-1:0]        pred_pc,
    output logic                           pred_ack,
    output logic                           pred_taken,
    output logic [bp_pkg::PHT_INDEX_W-1:0] pred_index,

    // resolve port
    input  logic                           res_req,
    input  bp_pkg::br_kind_t               res_kind,
    input  logic [bp_pkg::PHT_INDEX_W-1:0] res_index,
    input  logic                           res_taken,
    input  logic                           res_mispred,
    output logic                           res_ack,

    // statistics
    output logic [bp_pkg::STAT_W-1:0]      br_total,
    output logic [bp_pkg::STAT_W-1:0]      br_missed,
    output logic [bp_pkg::STAT_W-1:0]      jal_total,
    output logic [bp_pkg::STAT_W-1:0]      jal_missed,
    output logic [bp_pkg::STAT_W-1:0]      jalr_total,
    output logic [bp_pkg::STAT_W-1:0]      jalr_missed
);
    import bp_pkg::*;

    logic [PHT_INDEX_W-1:0] ghr;
    logic [PHT_INDEX_W-1:0] lookup_index;
    logic                   lookup_en;
    logic [CTR_W-1:0]       read_ctr;

    // training and stats from the resolve side
    logic                   upd_en;
    logic [PHT_INDEX_W-1:0] upd_index;
    logic                   upd_taken;
    logic                   stat_en;
    br_kind_t               stat_kind;
    logic                   stat_miss;

    bp_index_stage index_stage (
        .clk          (clk),
        .rst          (rst),
        .pred_req     (pred_req),
        .pred_pc      (pred_pc),
        .ghr          (ghr),
        .read_ctr     (read_ctr),
        .pred_ack     (pred_ack),
        .pred_taken   (pred_taken),
        .pred_index   (pred_index),
        .lookup_index (lookup_index),
        .lookup_en    (lookup_en)
    );

    pht_table pht (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .upd_en       (upd_en),
        .upd_index    (upd_index),
        .upd_taken    (upd_taken),
        .read_ctr     (read_ctr)
    );

    bp_resolve_stage resolve_stage (
        .clk          (clk),
        .rst          (rst),
        .res_req      (res_req),
        .res_kind     (res_kind),
        .res_index    (res_index),
        .res_taken    (res_taken),
        .res_mispred  (res_mispred),
        .res_ack      (res_ack),
        .ghr          (ghr),
        .upd_en       (upd_en),
        .upd_index    (upd_index),
        .upd_taken    (upd_taken),
        .stat_en      (stat_en),
        .stat_kind    (stat_kind),
        .stat_miss    (stat_miss)
    );

    mispredict_stats stats (
        .clk          (clk),
        .rst          (rst),
        .stat_en      (stat_en),
        .stat_kind    (stat_kind),
        .stat_miss    (stat_miss),
        .br_total     (br_total),
        .br_missed    (br_missed),
        .jal_total    (jal_total),
        .jal_missed   (jal_missed),
        .jalr_total   (jalr_total),
        .jalr_missed  (jalr_missed)
    );

endmodule : bp_unit

`default_nettype wire

// ==== src/mispredict_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module mispredict_stats (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stat_en,
    input  bp_pkg::br_kind_t          stat_kind,
    input  logic                      stat_miss,
    output logic [bp_pkg::STAT_W-1:0] br_total,
    output logic [bp_pkg::STAT_W-1:0] br_missed,
    output logic [bp_pkg::STAT_W-1:0] jal_total,
    output logic [bp_pkg::STAT_W-1:0] jal_missed,
    output logic [bp_pkg::STAT_W-1:0] jalr_total,
    output logic [bp_pkg::STAT_W-1:0] jalr_missed
);
    import bp_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            br_total    <= '0;
            br_missed   <= '0;
            jal_total   <= '0;
            jal_missed  <= '0;
            jalr_total  <= '0;
            jalr_missed <= '0;
        end else if (stat_en) begin
            case (stat_kind)
                kind_br: begin
                    br_total <= br_total + 1'b1;
                    if (stat_miss) begin
                        br_missed <= br_missed + 1'b1;
                    end
                end
                kind_jal: begin
                    jal_total <= jal_total + 1'b1;
                    if (stat_miss) begin
                        jal_missed <= jal_missed + 1'b1;
                    end
                end
                kind_jalr: begin
                    jalr_total <= jalr_total + 1'b1;
                    if (stat_miss) begin
                        jalr_missed <= jalr_missed + 1'b1;
                    end
                end
                // unknown kinds are not counted
                default: ;
            endcase
        end
    end

endmodule : mispredict_stats

`default_nettype wire

// ==== src/bp_resolve_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_resolve_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           res_req,
    input  bp_pkg::br_kind_t               res_kind,
    input  logic [bp_pkg::PHT_INDEX_W-1:0] res_index,
    input  logic                           res_taken,
    input  logic                           res_mispred,
    output logic                           res_ack,
    output logic [bp_pkg::PHT_INDEX_W-1:0] ghr,
    output logic                           upd_en,
    output logic [bp_pkg::PHT_INDEX_W-1:0] upd_index,
    output logic                           upd_taken,
    output logic                           stat_en,
    output bp_pkg::br_kind_t               stat_kind,
    output logic                           stat_miss
);
    import bp_pkg::*;

    hs_state_t state;
    logic      accept;
    logic      is_cond;

    assign accept  = (state == st_idle) && res_req;
    assign is_cond = (res_kind == kind_br);

    // two-state handshake, everything commits on the accepting edge
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (res_req) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (!res_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign res_ack = (state == st_ack);

    // history only tracks conditional branches
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (accept && is_cond) begin
            ghr <= {ghr[PHT_INDEX_W-2:0], res_taken};
        end
    end

    // training request into the table
    assign upd_en    = accept && is_cond;
    assign upd_index = res_index;
    assign upd_taken = res_taken;

    // every kind is counted
    assign stat_en   = accept;
    assign stat_kind = res_kind;
    assign stat_miss = res_mispred;

    kind_legal: assert property (@(posedge clk) disable iff (rst)
        res_req |-> res_kind inside {kind_br, kind_jal, kind_jalr})
        else $error("illegal branch kind on resolve port");

endmodule : bp_resolve_stage

`default_nettype wire

// ==== src/pht_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pht_table (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lookup_en,
    input  logic [bp_pkg::PHT_INDEX_W-1:0] lookup_index,
    input  logic                           upd_en,
    input  logic [bp_pkg::PHT_INDEX_W-1:0] upd_index,
    input  logic                           upd_taken,
    output logic [bp_pkg::CTR_W-1:0]       read_ctr
);
    import bp_pkg::*;

    localparam logic [CTR_W-1:0] CTR_MAX = {CTR_W{1'b1}};

    logic [CTR_W-1:0] ctrs [PHT_SIZE];
    logic [CTR_W-1:0] upd_old;
    logic [CTR_W-1:0] upd_new;

    // one saturating step on the addressed entry
    always_comb begin
        upd_old = ctrs[upd_index];
        upd_new = upd_old;
        if (upd_taken && upd_old != CTR_MAX) begin
            upd_new = upd_old + 1'b1;
        end else if (!upd_taken && upd_old != '0) begin
            upd_new = upd_old - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                ctrs[i] <= CTR_INIT;
            end
        end else if (upd_en) begin
            ctrs[upd_index] <= upd_new;
        end
    end

    // registered read, sees the old value on a same-cycle update
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            read_ctr <= ctrs[lookup_index];
        end
    end

endmodule : pht_table

`default_nettype wire

// ==== src/bp_index_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_index_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pred_req,
    input  logic [bp_pkg::PC_W-1:0]        pred_pc,
    input  logic [bp_pkg::PHT_INDEX_W-1:0] ghr,
    input  logic [bp_pkg::CTR_W-1:0]       read_ctr,
    output logic                           pred_ack,
    output logic                           pred_taken,
    output logic [bp_pkg::PHT_INDEX_W-1:0] pred_index,
    output logic [bp_pkg::PHT_INDEX_W-1:0] lookup_index,
    output logic                           lookup_en
);
    import bp_pkg::*;

    hs_state_t              state;
    logic [PHT_INDEX_W-1:0] index_q;
    logic                   accept;

    assign accept = (state == st_idle) && pred_req;

    // idle -> lookup -> read -> ack, then wait for req to drop
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            pred_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (pred_req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: state <= st_read;
                st_read: begin
                    state    <= st_ack;
                    pred_ack <= 1'b1;
                end
                st_ack: begin
                    if (!pred_req) begin
                        state    <= st_idle;
                        pred_ack <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // gshare hash, word aligned pc bits folded with history
    always_ff @(posedge clk) begin
        if (accept) begin
            index_q <= pred_pc[PHT_INDEX_W+1:2] ^ ghr;
        end
        // counter msb set means 2 or 3
        if (state == st_read) begin
            pred_taken <= read_ctr[CTR_W-1];
        end
    end

    assign lookup_en    = (state == st_lookup);
    assign lookup_index = index_q;
    assign pred_index   = index_q;

    // ack only after the table read has had its cycle
    ack_not_early: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle || state == st_lookup) |-> !pred_ack)
        else $error("pred_ack high before the table read finished");

endmodule : bp_index_stage

`default_nettype wire

// ==== src/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // table geometry
    localparam int PHT_SIZE    = 128;
    localparam int PHT_INDEX_W = $clog2(PHT_SIZE);

    localparam int PC_W = 32;

    // two-bit saturating counters
    localparam int CTR_W = 2;
    // weakly not taken
    localparam logic [CTR_W-1:0] CTR_INIT = 2'd1;

    // statistics counter width
    localparam int STAT_W = 32;

    // branch kinds carry their rv32i major opcode
    typedef enum logic [6:0] {
        kind_br   = 7'b1100011,
        kind_jal  = 7'b1101111,
        kind_jalr = 7'b1100111
    } br_kind_t;

    // four-phase handshake states
    // resolve side only uses idle and ack
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_lookup = 2'd1,
        st_read   = 2'd2,
        st_ack    = 2'd3
    } hs_state_t;

endpackage : bp_pkg

`default_nettype wire
